/* sim.f */
rtl/LcdPkg.sv
rtl/LcdPhaseIf.sv
rtl/StrobeGenerator.sv
rtl/LcdPhaseSequencer.sv
rtl/LcdSegmentMapper.sv
rtl/LcdLevelOutput.sv
rtl/LcdDriver.sv
tb/LcdDriver_asserts.sv
tb/LcdDriverTb.sv

/* tb/lcd_tests.txt */
# digit0 digit1 digit2 digit3 (p g f e d c b a), then active SEG mask for COM0 COM1 COM2 COM3
# all values hex, one test row per line
3F 06 5B 4F A2 67 F5 53
E6 6D 7D 07 29 75 6B 7E
7F 6F 00 FF CA C7 CF CF
00 00 00 00 00 00 00 00
FF FF FF FF FF FF FF FF
80 3F 80 06 19 4C 44 0C

/* tb/LcdDriverTb.sv */
// Testbench for the LCD driver, replays tb/lcd_tests.txt and checks the filtered level of every pin
`default_nettype none
`timescale 1ns/10ps

module LcdDriverTb;

	localparam int PHASE_CYCLES = 25;	// 25 MHz, 1 us per phase
	localparam int MEASURE_AT   = 10;	// Mid-phase, well past the 2 cycle latency
	localparam int MAX_ROWS     = 16;

	logic       Clock;
	logic       Reset;
	logic [7:0] Digit [4];
	logic [3:0] ComPin;
	logic [7:0] SegPin;
	logic [7:0] DigitRows [MAX_ROWS][4];	// Words per test row
	logic [7:0] MaskRows  [MAX_ROWS][4];	// Active SEG mask per COM
	int         RowCount;

	LcdDriver #(
		.CLOCK_HZ      (25_000_000),
		.CHANGE_COM_US (1)
	) u_LcdDriver (
		.Clock    (Clock),
		.Reset    (Reset),
		.Digit0_i (Digit[0]),
		.Digit1_i (Digit[1]),
		.Digit2_i (Digit[2]),
		.Digit3_i (Digit[3]),
		.ComPin_o (ComPin),
		.SegPin_o (SegPin)
	);

	always #20 Clock = ~Clock;	// 40 ns period

	task automatic failRun(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkValue(input string name, input int expected, input int actual);
		assert (actual == expected) else
			failRun($sformatf("mismatch at %0d ns: %s expected %0d, got %0d",
				$time, name, expected, actual));
	endtask

	task automatic driveDigits(input int row);
		for (int d = 0; d < 4; d++)
			Digit[d] <= DigitRows[row][d];
	endtask

	task automatic readTests();
		int    fd;
		int    n;
		string line;
		fd = $fopen("tb/lcd_tests.txt", "r");
		assert (fd != 0) else failRun("could not open tb/lcd_tests.txt");
		RowCount = 0;
		while (!$feof(fd) && RowCount < MAX_ROWS) begin
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 8 || line.substr(0, 0) == "#")
				continue;	// Header or blank line
			n = $sscanf(line, "%h %h %h %h %h %h %h %h",
				DigitRows[RowCount][0], DigitRows[RowCount][1],
				DigitRows[RowCount][2], DigitRows[RowCount][3],
				MaskRows[RowCount][0], MaskRows[RowCount][1],
				MaskRows[RowCount][2], MaskRows[RowCount][3]);
			assert (n == 8) else failRun($sformatf("malformed test row: %s", line));
			RowCount++;
		end
		$fclose(fd);
		assert (RowCount > 1) else failRun("test file holds fewer than two rows");
	endtask

	// Runs one phase from its first pin cycle, sums three mid-phase samples per pin
	task automatic runPhase(input int row, input int p, input int changeAt);
		int   comSum [4] = '{default: 0};
		int   segSum [8] = '{default: 0};
		int   com;
		int   expected;
		logic low;
		logic on;
		com = p % 4;
		low = (p >= 4);	// Second half of the frame is inverted
		for (int off = 0; off < PHASE_CYCLES; off++) begin
			if (off >= MEASURE_AT && off < MEASURE_AT + 3) begin
				for (int c = 0; c < 4; c++)
					comSum[c] += ComPin[c];
				for (int s = 0; s < 8; s++)
					segSum[s] += SegPin[s];
			end
			@(posedge Clock);
			if (off == changeAt)
				driveDigits(row + 1);	// Must not show before the next frame
			@(negedge Clock);
		end
		for (int c = 0; c < 4; c++) begin
			if (low)
				expected = (c == com) ? 0 : 2;
			else
				expected = (c == com) ? 3 : 1;
			checkValue($sformatf("ComPin_o[%0d] row %0d phase %0d", c, row, p),
				expected, comSum[c]);
		end
		for (int s = 0; s < 8; s++) begin
			on = MaskRows[row][com][s];
			if (low)
				expected = on ? 3 : 1;
			else
				expected = on ? 0 : 2;
			checkValue($sformatf("SegPin_o[%0d] row %0d phase %0d", s, row, p),
				expected, segSum[s]);
		end
	endtask

	always @(negedge Clock) begin
		assert (u_LcdDriver.u_LcdSegmentMapper.u_LcdDriverAsserts.FailCount == 0)
			else failRun("a bound assertion on the phase bus or COM levels failed");
	end

	initial begin
		int waited;
		int changeAt;
		Clock = 1'b0;
		Reset = 1'b0;
		for (int d = 0; d < 4; d++)
			Digit[d] = 8'h00;
		void'($urandom(42));
		readTests();
		@(posedge Clock);
		driveDigits(0);	// First frame latches row 0
		repeat (9) @(posedge Clock);
		Reset <= 1'b1;
		// First strobe lands 24 cycles after reset, pins stay low until then
		for (int i = 0; i < 20; i++) begin
			@(negedge Clock);
			checkValue("ComPin_o", 0, ComPin);
			checkValue("SegPin_o", 0, SegPin);
		end
		waited = 0;
		while (ComPin[0] !== 1'b1) begin	// COM0-H drives COM0 solid high
			assert (waited < 100) else failRun("timeout waiting for COM0 to start driving");
			@(negedge Clock);
			waited++;
		end
		for (int r = 0; r < RowCount; r++) begin
			for (int p = 0; p < 8; p++) begin
				changeAt = -1;
				if (p == 3 && r + 1 < RowCount)
					changeAt = $urandom_range(1, 8);	// Before the measure window
				runPhase(r, p, changeAt);
			end
		end
		if (u_LcdDriver.u_LcdSegmentMapper.u_LcdDriverAsserts.FailCount == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			failRun("a bound assertion on the phase bus or COM levels failed");
		end
	end

endmodule

`default_nettype wire

/* tb/LcdDriver_asserts.sv */
// Concurrent checks on the phase bus and the COM level codes, bound into the segment mapper
`default_nettype none
`timescale 1ns/10ps

module LcdDriverAsserts (
	input logic          Clock,
	input logic          Reset,
	input LcdPkg::phaseT PhaseNow,
	input logic          PhaseStep,
	input logic          FrameStart,
	input logic          Running,
	input LcdPkg::levelT ComLevel [LcdPkg::NUM_COM]
);
	import LcdPkg::*;

	int FailCount = 0;		// Failed checks so far, polled by the testbench
	logic [NUM_COM-1:0] ComActive;	// COMs sitting at an active code

	always_comb begin
		for (int c = 0; c < NUM_COM; c++) begin
			// Active codes are 3 in H and 0 in L, idle codes 1 and 2
			ComActive[c] = (ComLevel[c] == COM_ACTIVE_H) || (ComLevel[c] == COM_ACTIVE_L);
		end
	end

	StepWidth: assert property (@(posedge Clock) disable iff (!Reset) PhaseStep |=> !PhaseStep)
		else begin
			$error("PhaseStep stayed high for more than one cycle");
			FailCount++;
		end

	FrameAlign: assert property (@(posedge Clock) disable iff (!Reset)
		FrameStart |-> (PhaseStep && PhaseNow == PHASE_COM0_H))
		else begin
			$error("FrameStart seen away from a step into COM0-H");
			FailCount++;
		end

	OneComActive: assert property (@(posedge Clock) disable iff (!Reset)
		Running |=> $onehot(ComActive))
		else begin
			$error("active COM count is not exactly one while running");
			FailCount++;
		end

endmodule

bind LcdSegmentMapper LcdDriverAsserts u_LcdDriverAsserts (
	.Clock      (Clock),
	.Reset      (Reset),
	.PhaseNow   (Phase.Phase),
	.PhaseStep  (Phase.PhaseStep),
	.FrameStart (Phase.FrameStart),
	.Running    (Phase.Running),
	.ComLevel   (ComLevel_o)
);

`default_nettype wire

/* rtl/LcdDriver.sv */
// Top level of the 4-digit, 1/4 duty, 1/3 bias segment LCD driver; connect pins via RC filters
`default_nettype none
`timescale 1ns/10ps

module LcdDriver #(
	parameter int CLOCK_HZ      = 10_000_000,
	parameter int CHANGE_COM_US = 10	// Time per drive phase
)(
	input  logic       Clock,
	input  logic       Reset,
	input  logic [7:0] Digit0_i,	// Segment order p g f e d c b a
	input  logic [7:0] Digit1_i,
	input  logic [7:0] Digit2_i,
	input  logic [7:0] Digit3_i,
	output logic [3:0] ComPin_o,
	output logic [7:0] SegPin_o
);
	import LcdPkg::*;

	levelT ComLevel [NUM_COM];	// Mapper to output stage
	levelT SegLevel [NUM_SEG];

	LcdPhaseIf PhaseBus ();

	LcdPhaseSequencer #(
		.CLOCK_HZ      (CLOCK_HZ),
		.CHANGE_COM_US (CHANGE_COM_US)
	) u_LcdPhaseSequencer (
		.Clock (Clock),
		.Reset (Reset),
		.Phase (PhaseBus.Source)
	);

	LcdSegmentMapper u_LcdSegmentMapper (
		.Clock      (Clock),
		.Reset      (Reset),
		.Phase      (PhaseBus.Sink),
		.Digit0_i   (Digit0_i),
		.Digit1_i   (Digit1_i),
		.Digit2_i   (Digit2_i),
		.Digit3_i   (Digit3_i),
		.ComLevel_o (ComLevel),
		.SegLevel_o (SegLevel)
	);

	LcdLevelOutput u_LcdLevelOutput (
		.Clock      (Clock),
		.Reset      (Reset),
		.ComLevel_i (ComLevel),
		.SegLevel_i (SegLevel),
		.ComPin_o   (ComPin_o),
		.SegPin_o   (SegPin_o)
	);

endmodule

`default_nettype wire

/* rtl/LcdLevelOutput.sv */
// Four-level PWM source with a registered waveform select per COM and SEG pin, for RC filtering
`default_nettype none
`timescale 1ns/10ps

module LcdLevelOutput (
	input  logic          Clock,
	input  logic          Reset,
	input  LcdPkg::levelT ComLevel_i [LcdPkg::NUM_COM],
	input  LcdPkg::levelT SegLevel_i [LcdPkg::NUM_SEG],
	output logic [3:0]    ComPin_o,	// To COM lines through RC filter
	output logic [7:0]    SegPin_o	// To SEG lines through RC filter
);
	import LcdPkg::*;

	logic [1:0] PwmCount;	// Counts 0, 1, 2
	logic [3:0] Wave;	// Bit k is high for k of 3 cycles

	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset)
			PwmCount <= 2'd0;
		else if (PwmCount == 2'd2)
			PwmCount <= 2'd0;	// Modulo 3
		else
			PwmCount <= PwmCount + 2'd1;
	end

	assign Wave[0] = 1'b0;			// Ground
	assign Wave[1] = (PwmCount < 2'd1);	// 1/3 duty
	assign Wave[2] = (PwmCount < 2'd2);	// 2/3 duty
	assign Wave[3] = 1'b1;			// Full voltage

	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			ComPin_o <= '0;
			SegPin_o <= '0;
		end else begin
			for (int i = 0; i < NUM_COM; i++) begin
				ComPin_o[i] <= Wave[ComLevel_i[i]];
			end
			for (int i = 0; i < NUM_SEG; i++) begin
				SegPin_o[i] <= Wave[SegLevel_i[i]];
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/LcdSegmentMapper.sv */
// Latches the digit words once per frame and registers the level code of every COM and SEG pin
`default_nettype none
`timescale 1ns/10ps

module LcdSegmentMapper (
	input  logic          Clock,
	input  logic          Reset,
	LcdPhaseIf.Sink       Phase,
	input  logic [7:0]    Digit0_i,	// Rightmost digit, point bit is the colon
	input  logic [7:0]    Digit1_i,
	input  logic [7:0]    Digit2_i,
	input  logic [7:0]    Digit3_i,	// Leftmost digit
	output LcdPkg::levelT ComLevel_o [LcdPkg::NUM_COM],
	output LcdPkg::levelT SegLevel_o [LcdPkg::NUM_SEG]
);
	import LcdPkg::*;

	localparam int NUM_DIGIT = NUM_SEG / 2;	// Two SEG lines per digit

	logic [7:0] DigitIn    [NUM_DIGIT];	// Live inputs as an array
	logic [7:0] FrameLatch [NUM_DIGIT];	// Words shown in the current frame
	logic [7:0] FrameDigit [NUM_DIGIT];	// Latch, or inputs on the frame edge
	levelT      ComNext    [NUM_COM];
	levelT      SegNext    [NUM_SEG];
	logic       LowHalf;			// Inverted half of the frame
	logic [1:0] ComIdx;			// Active common line

	function automatic levelT comCode(input logic Active, input logic Low);
		if (Low)
			return Active ? COM_ACTIVE_L : COM_IDLE_L;
		return Active ? COM_ACTIVE_H : COM_IDLE_H;
	endfunction

	function automatic levelT segCode(input logic On, input logic Low);
		if (Low)
			return On ? SEG_ON_L : SEG_OFF_L;
		return On ? SEG_ON_H : SEG_OFF_H;
	endfunction

	assign DigitIn[0] = Digit0_i;
	assign DigitIn[1] = Digit1_i;
	assign DigitIn[2] = Digit2_i;
	assign DigitIn[3] = Digit3_i;

	assign LowHalf = Phase.Phase[2];	// Polarity bit
	assign ComIdx  = Phase.Phase[1:0];

	// Frame latch, only read once Running
	always_ff @(posedge Clock) begin
		if (Phase.FrameStart)
			FrameLatch <= DigitIn;
	end

	always_comb begin
		for (int d = 0; d < NUM_DIGIT; d++) begin
			// Bypass so COM0-H already shows the new words
			FrameDigit[d] = Phase.FrameStart ? DigitIn[d] : FrameLatch[d];
		end
	end

	always_comb begin
		for (int c = 0; c < NUM_COM; c++) begin
			ComNext[c] = comCode(ComIdx == 2'(c), LowHalf);
		end
		for (int d = 0; d < NUM_DIGIT; d++) begin
			SegNext[2*d]   = segCode(FrameDigit[d][EVEN_SEG_BIT[ComIdx]], LowHalf);
			SegNext[2*d+1] = segCode(FrameDigit[d][ODD_SEG_BIT[ComIdx]], LowHalf);
		end
	end

	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			ComLevel_o <= '{default: '0};
			SegLevel_o <= '{default: '0};
		end else if (!Phase.Running) begin
			ComLevel_o <= '{default: '0};	// Glass held at ground until start
			SegLevel_o <= '{default: '0};
		end else begin
			ComLevel_o <= ComNext;	// One cycle behind Phase
			SegLevel_o <= SegNext;
		end
	end

endmodule

`default_nettype wire

/* rtl/LcdPhaseSequencer.sv */
// Eight-phase drive FSM (COM0..3 high half, then low half), paced by a strobe generator
`default_nettype none
`timescale 1ns/10ps

module LcdPhaseSequencer #(
	parameter int CLOCK_HZ      = 10_000_000,
	parameter int CHANGE_COM_US = 10
)(
	input  logic Clock,
	input  logic Reset,
	LcdPhaseIf.Source Phase
);
	import LcdPkg::*;

	logic Strobe;	// Time to move to the next phase

	StrobeGenerator #(
		.CLOCK_HZ  (CLOCK_HZ),
		.PERIOD_US (CHANGE_COM_US)
	) u_StrobeGenerator (
		.Clock    (Clock),
		.Reset    (Reset),
		.Strobe_o (Strobe)
	);

	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			Phase.Phase      <= PHASE_COM0_H;
			Phase.PhaseStep  <= 1'b0;
			Phase.FrameStart <= 1'b0;
			Phase.Running    <= 1'b0;
		end else begin
			Phase.PhaseStep  <= Strobe;	// Lines up with the new Phase
			Phase.FrameStart <= 1'b0;
			if (Strobe && !Phase.Running) begin
				// First strobe starts the frame at COM0-H without stepping
				Phase.Running    <= 1'b1;
				Phase.FrameStart <= 1'b1;
			end else if (Strobe) begin
				Phase.Phase      <= Phase.Phase + 3'd1;	// COM3-L wraps to COM0-H
				Phase.FrameStart <= (Phase.Phase == PHASE_COM3_L);
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/StrobeGenerator.sv */
// Free-running divider, gives a one-cycle strobe every PERIOD_US microseconds of Clock
`default_nettype none
`timescale 1ns/10ps

module StrobeGenerator #(
	parameter int CLOCK_HZ  = 10_000_000,
	parameter int PERIOD_US = 10
)(
	input  logic Clock,
	input  logic Reset,
	output logic Strobe_o
);

	localparam int CYCLES = CLOCK_HZ / 1_000_000 * PERIOD_US;	// Cycles per strobe
	localparam int WIDTH  = (CYCLES > 1) ? $clog2(CYCLES) : 1;	// Counter width

	localparam logic [WIDTH-1:0] RELOAD = WIDTH'(CYCLES - 1);

	logic [WIDTH-1:0] Count;	// Cycles left until the next strobe

	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			Count <= RELOAD;	// Full period before first strobe
		end else if (Count == '0) begin
			Count <= RELOAD;	// Restart period
		end else begin
			Count <= Count - 1'b1;
		end
	end

	// Strobe while the counter sits at zero
	assign Strobe_o = (Count == '0);

endmodule

`default_nettype wire

/* rtl/LcdPhaseIf.sv */
// Phase state bundle, driven by the phase sequencer and read by the segment mapper
`default_nettype none
`timescale 1ns/10ps

interface LcdPhaseIf;
	import LcdPkg::*;

	phaseT Phase;		// Current drive phase
	logic  PhaseStep;	// One cycle, Phase just advanced
	logic  FrameStart;	// One cycle, Phase just became COM0-H
	logic  Running;		// High from the first strobe on

	modport Source (
		output Phase,
		output PhaseStep,
		output FrameStart,
		output Running
	);

	modport Sink (
		input  Phase,
		input  PhaseStep,
		input  FrameStart,
		input  Running
	);

endinterface

`default_nettype wire

/* rtl/LcdPkg.sv */
// Shared types and constants for the segment LCD driver, imported by every RTL block
`default_nettype none

package LcdPkg;

	localparam int NUM_COM = 4;	// Common lines, 1/4 duty
	localparam int NUM_SEG = 8;	// Segment lines, two per digit

	typedef logic [1:0] levelT;	// 0, 1/3, 2/3, full voltage
	typedef logic [2:0] phaseT;	// {polarity, COM index}

	localparam phaseT PHASE_COM0_H = 3'd0;	// First phase of a frame
	localparam phaseT PHASE_COM3_L = 3'd7;	// Last phase, wraps to COM0-H

	// H half: COM driven up, SEG pulled down for an on segment
	localparam levelT COM_ACTIVE_H = 2'd3;
	localparam levelT COM_IDLE_H   = 2'd1;
	localparam levelT SEG_ON_H     = 2'd0;
	localparam levelT SEG_OFF_H    = 2'd2;

	// L half: mirror image so the glass sees no DC
	localparam levelT COM_ACTIVE_L = 2'd0;
	localparam levelT COM_IDLE_L   = 2'd2;
	localparam levelT SEG_ON_L     = 2'd3;
	localparam levelT SEG_OFF_L    = 2'd1;

	// Digit bit shown on SEG 2d, indexed by COM
	localparam logic [2:0] EVEN_SEG_BIT [NUM_COM] = '{
		3'd7,	// COM0, point or colon
		3'd2,	// COM1, segment c
		3'd1,	// COM2, segment b
		3'd0	// COM3, segment a
	};

	// Digit bit shown on SEG 2d+1, indexed by COM
	localparam logic [2:0] ODD_SEG_BIT [NUM_COM] = '{
		3'd3,	// COM0, segment d
		3'd4,	// COM1, segment e
		3'd6,	// COM2, segment g
		3'd5	// COM3, segment f
	};

endpackage

`default_nettype wire
